// ==== conv_pkg.sv ====
package conv_pkg;

	localparam int PIXEL_W  = 8;
	localparam int WEIGHT_W = 8;
	// 24 bits covers 49 taps of full-scale products plus bias.
	localparam int ACC_W    = 24;
	localparam int RESULT_W = 16;
	localparam int COORD_W  = 8;
	localparam int ADDR_W   = 10;

	typedef logic signed [PIXEL_W-1:0]  pixel_t;
	typedef logic signed [WEIGHT_W-1:0] weight_t;
	typedef logic signed [ACC_W-1:0]    acc_t;
	typedef logic signed [RESULT_W-1:0] result_t;

	typedef struct packed {
		logic [COORD_W-1:0] row;
		logic [COORD_W-1:0] col;
	} win_tag_t;

	// one bus word per result.
	typedef struct packed {
		logic [COORD_W-1:0] row;
		logic [COORD_W-1:0] col;
		result_t            value;
	} conv_result_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [31:0]       dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// byte addresses; the bus carries word addresses.
	localparam logic [ADDR_W+1:0] REG_PIXEL       = 'h00;
	localparam logic [ADDR_W+1:0] REG_CTRL        = 'h04;
	localparam logic [ADDR_W+1:0] REG_STATUS      = 'h08;
	localparam logic [ADDR_W+1:0] REG_RESULT      = 'h0C;
	localparam logic [ADDR_W+1:0] REG_BIAS        = 'h3C;
	localparam logic [ADDR_W+1:0] REG_WEIGHT_BASE = 'h40;

endpackage

// ==== conv_line_buffer.sv ====
module conv_line_buffer import conv_pkg::*; #(
	parameter int IFM_SIZE    = 28,
	parameter int KERNEL_SIZE = 5
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     pixel_push,
	input  pixel_t                                   pixel,
	output pixel_t [KERNEL_SIZE*KERNEL_SIZE-1:0]     window
);

	localparam int DEPTH = (KERNEL_SIZE-1)*IFM_SIZE + KERNEL_SIZE;

	pixel_t sr [DEPTH];

	// sr[0] holds the newest pixel.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH; i++)
				sr[i] <= '0;
		end
		else if (pixel_push)
		begin
			sr[0] <= pixel;
			for (int i = 1; i < DEPTH; i++)
				sr[i] <= sr[i-1];
		end
	end

	// tap r*K+c sits r rows and c columns past the window origin, oldest at tap 0.
	for (genvar r = 0; r < KERNEL_SIZE; r++)
	begin : g_row
		for (genvar c = 0; c < KERNEL_SIZE; c++)
		begin : g_col
			assign window[r*KERNEL_SIZE + c] =
				sr[(KERNEL_SIZE-1-r)*IFM_SIZE + (KERNEL_SIZE-1-c)];
		end
	end

	// the bus slave must hold off pushes until reset is released.
	a_no_push_in_reset: assert property (
		@(posedge clk) reset |-> !pixel_push
	);

	a_pixel_known: assert property (
		@(posedge clk) disable iff (reset) pixel_push |-> !$isunknown(pixel)
	);

endmodule

// ==== conv_window_ctrl.sv ====
module conv_window_ctrl import conv_pkg::*; #(
	parameter int IFM_SIZE    = 28,
	parameter int KERNEL_SIZE = 5
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     frame_start,
	input  logic     pixel_push,
	output logic     win_valid,
	output win_tag_t win_tag,
	output logic     frame_done
);

	localparam logic [COORD_W-1:0] LAST     = COORD_W'(IFM_SIZE - 1);
	localparam logic [COORD_W-1:0] EDGE_OFF = COORD_W'(KERNEL_SIZE - 1);

	// position of the pixel currently being pushed.
	logic [COORD_W-1:0] row;
	logic [COORD_W-1:0] col;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			row        <= '0;
			col        <= '0;
			frame_done <= 1'b0;
		end
		else if (frame_start)
		begin
			row        <= '0;
			col        <= '0;
			frame_done <= 1'b0;
		end
		else if (pixel_push)
		begin
			if (col == LAST)
			begin
				col <= '0;
				row <= (row == LAST) ? '0 : row + 1'b1;
			end
			else
			begin
				col <= col + 1'b1;
			end
			if (row == LAST && col == LAST)
				frame_done <= 1'b1;
		end
	end

	// a window completes once the bottom-right tap arrives.
	assign win_valid   = pixel_push && (row >= EDGE_OFF) && (col >= EDGE_OFF);
	assign win_tag.row = row - EDGE_OFF;
	assign win_tag.col = col - EDGE_OFF;

endmodule

// ==== conv_weight_bank.sv ====
module conv_weight_bank import conv_pkg::*; #(
	parameter int KERNEL_SIZE = 5
) (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          weight_we,
	input  logic [$clog2(KERNEL_SIZE*KERNEL_SIZE)-1:0]    weight_idx,
	input  weight_t                                       weight_wdata,
	input  logic                                          bias_we,
	input  result_t                                       bias_wdata,
	output weight_t [KERNEL_SIZE*KERNEL_SIZE-1:0]         weights,
	output result_t                                       bias
);

	localparam int NTAPS = KERNEL_SIZE*KERNEL_SIZE;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			weights <= '0;
			bias    <= '0;
		end
		else
		begin
			// indexes past the last tap are ignored.
			if (weight_we && int'(weight_idx) < NTAPS)
				weights[weight_idx] <= weight_wdata;
			if (bias_we)
				bias <= bias_wdata;
		end
	end

endmodule

// ==== conv_mac.sv ====
module conv_mac import conv_pkg::*; #(
	parameter int KERNEL_SIZE = 5
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      win_valid,
	input  win_tag_t                                  win_tag,
	input  pixel_t  [KERNEL_SIZE*KERNEL_SIZE-1:0]     window,
	input  weight_t [KERNEL_SIZE*KERNEL_SIZE-1:0]     weights,
	input  result_t                                   bias,
	input  logic                                      relu_en,
	output logic                                      res_valid,
	output conv_result_t                              res
);

	localparam int NTAPS  = KERNEL_SIZE*KERNEL_SIZE;
	localparam int PROD_W = PIXEL_W + WEIGHT_W;
	localparam acc_t SAT_MAX = (1 << (RESULT_W-1)) - 1;
	localparam acc_t SAT_MIN = -(1 << (RESULT_W-1));

	logic                    v0;
	logic                    v1;
	logic                    v2;
	win_tag_t                tag0;
	win_tag_t                tag1;
	win_tag_t                tag2;
	logic signed [PROD_W-1:0] prod [NTAPS];
	acc_t                    tree_sum;
	acc_t                    sum_q;
	acc_t                    biased;
	result_t                 clipped;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			v0        <= 1'b0;
			v1        <= 1'b0;
			v2        <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			v0        <= win_valid;
			v1        <= v0;
			v2        <= v1;
			res_valid <= v2;
		end
	end

	// tag is held one cycle while the line buffer settles on the new taps.
	always_ff @(posedge clk)
	begin
		tag0 <= win_tag;
		tag1 <= tag0;
		tag2 <= tag1;
		for (int i = 0; i < NTAPS; i++)
			prod[i] <= window[i] * weights[i];
		sum_q <= tree_sum;
		res.row   <= tag2.row;
		res.col   <= tag2.col;
		res.value <= clipped;
	end

	always_comb
	begin
		tree_sum = '0;
		for (int i = 0; i < NTAPS; i++)
			tree_sum = tree_sum + prod[i];
	end

	// bias, relu, then clamp to the 16-bit signed range.
	always_comb
	begin
		biased = sum_q + bias;
		if (relu_en && biased < 0)
			biased = '0;
		if (biased > SAT_MAX)
			clipped = result_t'(SAT_MAX);
		else if (biased < SAT_MIN)
			clipped = result_t'(SAT_MIN);
		else
			clipped = result_t'(biased);
	end

endmodule

// ==== conv_result_fifo.sv ====
module conv_result_fifo import conv_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 push,
	input  conv_result_t                         push_data,
	input  logic                                 pop,
	output conv_result_t                         head,
	output logic [$clog2(FIFO_DEPTH+1)-1:0]      count,
	output logic [$clog2(FIFO_DEPTH+1)-1:0]      free_slots
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH+1);

	conv_result_t     mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH-1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign head       = mem[rd_ptr];
	assign free_slots = CNT_W'(FIFO_DEPTH) - count;

	// the bus slave's in-flight accounting has to keep the MAC from overrunning.
	a_no_overflow: assert property (
		@(posedge clk) disable iff (reset) push |-> (int'(count) < FIFO_DEPTH)
	);

	a_no_underflow: assert property (
		@(posedge clk) disable iff (reset) pop |-> (count != '0)
	);

endmodule

// ==== conv_wb_regs.sv ====
module conv_wb_regs import conv_pkg::*; #(
	parameter int KERNEL_SIZE = 5,
	parameter int FIFO_DEPTH  = 16
) (
	input  logic                                          clk,
	input  logic                                          reset,
	input  wb_req_t                                       wb_req,
	output wb_rsp_t                                       wb_rsp,
	output logic                                          pixel_push,
	output pixel_t                                        pixel,
	output logic                                          frame_start,
	output logic                                          relu_en,
	output logic                                          weight_we,
	output logic [$clog2(KERNEL_SIZE*KERNEL_SIZE)-1:0]    weight_idx,
	output weight_t                                       weight_wdata,
	output logic                                          bias_we,
	output result_t                                       bias_wdata,
	input  weight_t [KERNEL_SIZE*KERNEL_SIZE-1:0]         weights,
	input  result_t                                       bias,
	input  logic                                          frame_done,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0]               fifo_count,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0]               free_slots,
	input  conv_result_t                                  fifo_head,
	output logic                                          fifo_pop
);

	localparam int NTAPS = KERNEL_SIZE*KERNEL_SIZE;
	localparam int IDX_W = $clog2(NTAPS);
	// cycles from a pixel push until its result is counted by the FIFO.
	localparam int LATENCY = 4;

	logic [ADDR_W+1:0]  byte_adr;
	logic [ADDR_W-1:0]  adr_off;
	logic               hit_weight;
	logic               is_pixel_wr;
	logic               pix_room;
	logic               ack_q;
	logic               wr_strobe;
	logic               rd_strobe;
	logic [LATENCY-1:0] push_pipe;
	logic [31:0]        rd_data;

	assign byte_adr    = {wb_req.adr, 2'b00};
	assign adr_off     = wb_req.adr - ADDR_W'(REG_WEIGHT_BASE >> 2);
	assign hit_weight  = (byte_adr >= REG_WEIGHT_BASE) && (int'(adr_off) < NTAPS);
	assign is_pixel_wr = wb_req.we && (byte_adr == REG_PIXEL);

	// every push in the pipe may still land a result, so count them all.
	assign pix_room = (int'(free_slots) - $countones(push_pipe)) >= 1;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ack_q     <= 1'b0;
			push_pipe <= '0;
			relu_en   <= 1'b0;
		end
		else
		begin
			ack_q     <= wb_req.cyc && wb_req.stb && !ack_q && (!is_pixel_wr || pix_room);
			push_pipe <= {push_pipe[LATENCY-2:0], pixel_push};
			if (wr_strobe && byte_adr == REG_CTRL)
				relu_en <= wb_req.dat[1];
		end
	end

	// register writes and pops take effect in the ack cycle.
	assign wr_strobe = ack_q && wb_req.we;
	assign rd_strobe = ack_q && !wb_req.we;

	assign pixel_push   = wr_strobe && (byte_adr == REG_PIXEL);
	assign pixel        = wb_req.dat[PIXEL_W-1:0];
	assign frame_start  = wr_strobe && (byte_adr == REG_CTRL) && wb_req.dat[0];
	assign weight_we    = wr_strobe && hit_weight;
	assign weight_idx   = adr_off[IDX_W-1:0];
	assign weight_wdata = wb_req.dat[WEIGHT_W-1:0];
	assign bias_we      = wr_strobe && (byte_adr == REG_BIAS);
	assign bias_wdata   = wb_req.dat[RESULT_W-1:0];
	assign fifo_pop     = rd_strobe && (byte_adr == REG_RESULT) && (fifo_count != '0);

	always_comb
	begin
		rd_data = '0;
		case (byte_adr)
			REG_CTRL:
				rd_data = {30'b0, relu_en, 1'b0};
			REG_STATUS:
				rd_data = {23'b0, frame_done, 8'(fifo_count)};
			REG_RESULT:
				rd_data = (fifo_count != '0) ? fifo_head : '0;
			REG_BIAS:
				rd_data = 32'(bias);
			default:
			begin
				if (hit_weight)
					rd_data = 32'(weights[weight_idx]);
			end
		endcase
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_data;

	// classic bus: the master keeps the cycle open until it sees ack.
	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (reset) wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)
	);

endmodule

// ==== conv_layer_top.sv ====
module conv_layer_top import conv_pkg::*; #(
	parameter int IFM_SIZE    = 28,
	parameter int KERNEL_SIZE = 5,
	parameter int FIFO_DEPTH  = 16
) (
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	localparam int NTAPS = KERNEL_SIZE*KERNEL_SIZE;
	localparam int IDX_W = $clog2(NTAPS);
	localparam int CNT_W = $clog2(FIFO_DEPTH+1);

	logic                  pixel_push;
	pixel_t                pixel;
	logic                  frame_start;
	logic                  frame_done;
	logic                  relu_en;
	logic                  weight_we;
	logic [IDX_W-1:0]      weight_idx;
	weight_t               weight_wdata;
	logic                  bias_we;
	result_t               bias_wdata;
	weight_t [NTAPS-1:0]   weights;
	result_t               bias;
	pixel_t  [NTAPS-1:0]   window;
	logic                  win_valid;
	win_tag_t              win_tag;
	logic                  res_valid;
	conv_result_t          res;
	logic                  fifo_pop;
	conv_result_t          fifo_head;
	logic [CNT_W-1:0]      fifo_count;
	logic [CNT_W-1:0]      free_slots;

	conv_wb_regs #(.KERNEL_SIZE(KERNEL_SIZE), .FIFO_DEPTH(FIFO_DEPTH)) u_wb_regs (
		.clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.pixel_push(pixel_push), .pixel(pixel), .frame_start(frame_start),
		.relu_en(relu_en), .weight_we(weight_we), .weight_idx(weight_idx),
		.weight_wdata(weight_wdata), .bias_we(bias_we), .bias_wdata(bias_wdata),
		.weights(weights), .bias(bias), .frame_done(frame_done),
		.fifo_count(fifo_count), .free_slots(free_slots), .fifo_head(fifo_head),
		.fifo_pop(fifo_pop)
	);

	conv_line_buffer #(.IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE)) u_line_buffer (
		.clk(clk), .reset(reset), .pixel_push(pixel_push), .pixel(pixel), .window(window)
	);

	conv_window_ctrl #(.IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE)) u_window_ctrl (
		.clk(clk), .reset(reset), .frame_start(frame_start), .pixel_push(pixel_push),
		.win_valid(win_valid), .win_tag(win_tag), .frame_done(frame_done)
	);

	conv_weight_bank #(.KERNEL_SIZE(KERNEL_SIZE)) u_weight_bank (
		.clk(clk), .reset(reset), .weight_we(weight_we), .weight_idx(weight_idx),
		.weight_wdata(weight_wdata), .bias_we(bias_we), .bias_wdata(bias_wdata),
		.weights(weights), .bias(bias)
	);

	conv_mac #(.KERNEL_SIZE(KERNEL_SIZE)) u_mac (
		.clk(clk), .reset(reset), .win_valid(win_valid), .win_tag(win_tag),
		.window(window), .weights(weights), .bias(bias), .relu_en(relu_en),
		.res_valid(res_valid), .res(res)
	);

	conv_result_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_result_fifo (
		.clk(clk), .reset(reset), .push(res_valid), .push_data(res), .pop(fifo_pop),
		.head(fifo_head), .count(fifo_count), .free_slots(free_slots)
	);

endmodule

// ==== tb_conv_layer.sv ====
module tb_conv_layer import conv_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IFM      = 8;
	localparam int K        = 3;
	localparam int NTAPS    = K*K;
	localparam int NPIX     = IFM*IFM;
	localparam int OUT      = IFM - K + 1;
	// signed 16-bit output range.
	localparam int SAT_MAX  = 32767;
	localparam int SAT_MIN  = -32768;
	// a stalled pixel write is withdrawn after this many cycles so a result can be popped.
	localparam int STALL_WAIT = 8;
	// six frames of 64 pixels at about 20 cycles each, with a wide margin.
	localparam int TIMEOUT_CYCLES = 20000;

	logic         clk;
	logic         reset;
	wb_req_t      wb_req;
	wb_rsp_t      wb_rsp;
	int           cycles;
	int           errors;
	int           checks;
	int           tests;
	int           failed_tests;
	int           stalls;
	pixel_t       img [NPIX];
	weight_t      kern [NTAPS];
	result_t      bias_v;
	logic         relu;
	conv_result_t exp_q [$];
	conv_result_t got_q [$];

	conv_layer_top #(.IFM_SIZE(IFM), .KERNEL_SIZE(K), .FIFO_DEPTH(16)) u_conv_layer_top (
		.clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp)
	);

	initial
		clk = 1'b0;

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("error: %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_result(input string name, input conv_result_t exp,
		input conv_result_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("error: %s expected (%0d,%0d)=%0d actual (%0d,%0d)=%0d", name,
				exp.row, exp.col, exp.value, act.row, act.col, act.value);
		end
	endtask

	// called 2 ns after a rising edge, returns 2 ns after one.
	task automatic bus_transfer(input logic we, input logic [ADDR_W+1:0] byte_adr,
		input logic [31:0] wdata, input int max_wait, output logic [31:0] rdata,
		output logic acked);
		int waited;
		waited = 0;
		acked  = 1'b0;
		rdata  = '0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = byte_adr[ADDR_W+1:2];
		wb_req.dat = wdata;
		while (!acked && (max_wait == 0 || waited < max_wait))
		begin
			@(posedge clk);
			#2;
			waited++;
			if (wb_rsp.ack)
			begin
				acked = 1'b1;
				rdata = wb_rsp.dat;
			end
		end
		// on a withdrawn write ack was low here, so dropping the cycle now is clean.
		if (acked)
		begin
			@(posedge clk);
			#2;
		end
		wb_req = '0;
	endtask

	task automatic wb_write(input logic [ADDR_W+1:0] byte_adr, input logic [31:0] wdata);
		logic [31:0] unused;
		logic        ok;
		bus_transfer(1'b1, byte_adr, wdata, 0, unused, ok);
	endtask

	task automatic wb_read(input logic [ADDR_W+1:0] byte_adr, output logic [31:0] rdata);
		logic ok;
		bus_transfer(1'b0, byte_adr, '0, 0, rdata, ok);
	endtask

	function automatic conv_result_t make_result(input int r, input int c, input int v);
		conv_result_t x;
		x.row   = COORD_W'(r);
		x.col   = COORD_W'(c);
		x.value = result_t'(v);
		return x;
	endfunction

	// expected results in raster order from image, kernel, bias and relu.
	function automatic void build_model();
		int acc;
		exp_q.delete();
		for (int r = 0; r < OUT; r++)
		begin
			for (int c = 0; c < OUT; c++)
			begin
				acc = int'(bias_v);
				for (int i = 0; i < K; i++)
					for (int j = 0; j < K; j++)
						acc += int'(img[(r+i)*IFM + c + j]) * int'(kern[i*K + j]);
				if (relu && acc < 0)
					acc = 0;
				if (acc > SAT_MAX)
					acc = SAT_MAX;
				else if (acc < SAT_MIN)
					acc = SAT_MIN;
				exp_q.push_back(make_result(r, c, acc));
			end
		end
	endfunction

	function automatic void fill_constant(input int v);
		exp_q.delete();
		for (int r = 0; r < OUT; r++)
			for (int c = 0; c < OUT; c++)
				exp_q.push_back(make_result(r, c, v));
	endfunction

	task automatic load_kernel();
		for (int i = 0; i < NTAPS; i++)
			wb_write(REG_WEIGHT_BASE + 4*i, 32'(kern[i]));
		wb_write(REG_BIAS, 32'(bias_v));
	endtask

	task automatic pop_result(input string name);
		logic [31:0] status;
		logic [31:0] d;
		wb_read(REG_STATUS, status);
		if (status[7:0] != 0)
		begin
			wb_read(REG_RESULT, d);
			if (got_q.size() >= exp_q.size())
			begin
				errors++;
				$display("error: %s returned more results than the frame has", name);
			end
			else
				compare_result(name, exp_q[got_q.size()], conv_result_t'(d));
			got_q.push_back(conv_result_t'(d));
		end
	endtask

	// pushes the image without reading; a stalled write is retried after one pop.
	task automatic run_frame(input string name);
		logic [31:0] d;
		logic        ok;
		got_q.delete();
		wb_write(REG_CTRL, {30'b0, relu, 1'b1});
		for (int i = 0; i < NPIX; i++)
		begin
			ok = 1'b0;
			while (!ok)
			begin
				bus_transfer(1'b1, REG_PIXEL, 32'(img[i]), STALL_WAIT, d, ok);
				if (!ok)
				begin
					stalls++;
					pop_result(name);
				end
			end
		end
		while (got_q.size() < exp_q.size())
			pop_result(name);
		// fifo empty and frame_done set.
		wb_read(REG_STATUS, d);
		compare_word({name, " status"}, 32'h0000_0100, d);
	endtask

	task automatic end_test(input string name, input int err_at_start);
		tests++;
		if (errors == err_at_start)
			$display("%s: ok", name);
		else
		begin
			failed_tests++;
			$display("%s: %0d errors", name, errors - err_at_start);
		end
	endtask

	task automatic test_reset_values();
		logic [31:0] d;
		int e;
		e = errors;
		wb_read(REG_STATUS, d);
		compare_word("reset_values status", 32'h0, d);
		wb_read(REG_RESULT, d);
		compare_word("reset_values result", 32'h0, d);
		wb_read(REG_CTRL, d);
		compare_word("reset_values ctrl", 32'h0, d);
		end_test("reset_values", e);
	endtask

	task automatic test_register_readback();
		logic [31:0] w;
		logic [31:0] d;
		int e;
		e = errors;
		for (int i = 0; i < NTAPS; i++)
		begin
			w = $urandom;
			wb_write(REG_WEIGHT_BASE + 4*i, w);
			wb_read(REG_WEIGHT_BASE + 4*i, d);
			compare_word("register_readback weight", {{24{w[7]}}, w[7:0]}, d);
		end
		w = $urandom;
		wb_write(REG_BIAS, w);
		wb_read(REG_BIAS, d);
		compare_word("register_readback bias", {{16{w[15]}}, w[15:0]}, d);
		for (int i = 1; i >= 0; i--)
		begin
			wb_write(REG_CTRL, 32'(i) << 1);
			wb_read(REG_CTRL, d);
			compare_word("register_readback ctrl", 32'(i) << 1, d);
		end
		end_test("register_readback", e);
	endtask

	task automatic test_identity_kernel();
		int e;
		e = errors;
		for (int i = 0; i < NPIX; i++)
			img[i] = pixel_t'($urandom);
		for (int i = 0; i < NTAPS; i++)
			kern[i] = (i == NTAPS/2) ? 8'sd1 : 8'sd0;
		bias_v = '0;
		relu   = 1'b0;
		load_kernel();
		exp_q.delete();
		for (int r = 0; r < OUT; r++)
			for (int c = 0; c < OUT; c++)
				exp_q.push_back(make_result(r, c, int'(img[(r+1)*IFM + c + 1])));
		run_frame("identity_kernel");
		end_test("identity_kernel", e);
	endtask

	// the same image, kernel and bias run once without and once with relu.
	task automatic test_random_kernel();
		int e;
		e = errors;
		for (int i = 0; i < NPIX; i++)
			img[i] = pixel_t'($urandom);
		for (int i = 0; i < NTAPS; i++)
			kern[i] = weight_t'($urandom);
		bias_v = result_t'(int'($urandom_range(4000)) - 2000);
		load_kernel();
		relu = 1'b0;
		build_model();
		run_frame("random_kernel");
		relu = 1'b1;
		build_model();
		run_frame("random_kernel relu");
		foreach (got_q[i])
		begin
			if (got_q[i].value < 0)
			begin
				errors++;
				$display("error: random_kernel relu expected non-negative actual %0d",
					got_q[i].value);
			end
		end
		end_test("random_kernel", e);
	endtask

	task automatic test_saturation();
		int e;
		e = errors;
		relu   = 1'b0;
		bias_v = result_t'(SAT_MAX);
		for (int i = 0; i < NPIX; i++)
			img[i] = 8'sd127;
		for (int i = 0; i < NTAPS; i++)
			kern[i] = 8'sd127;
		load_kernel();
		fill_constant(SAT_MAX);
		run_frame("saturation high");
		for (int i = 0; i < NTAPS; i++)
			kern[i] = -8'sd128;
		load_kernel();
		fill_constant(SAT_MIN);
		run_frame("saturation low");
		end_test("saturation", e);
	endtask

	task automatic test_back_pressure();
		int e;
		e = errors;
		stalls = 0;
		for (int i = 0; i < NPIX; i++)
			img[i] = pixel_t'($urandom);
		for (int i = 0; i < NTAPS; i++)
			kern[i] = weight_t'($urandom);
		bias_v = result_t'(int'($urandom_range(4000)) - 2000);
		relu   = 1'b0;
		load_kernel();
		build_model();
		run_frame("back_pressure");
		if (stalls == 0)
		begin
			errors++;
			$display("error: back_pressure saw no pixel write held off by a full FIFO");
		end
		end_test("back_pressure", e);
	endtask

	initial
	begin
		reset        = 1'b1;
		wb_req       = '0;
		cycles       = 0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		failed_tests = 0;
		stalls       = 0;
		void'($urandom(32'hf12d_b8ae));
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		@(posedge clk);
		#2;
		test_reset_values();
		test_register_readback();
		test_identity_kernel();
		test_random_kernel();
		test_saturation();
		test_back_pressure();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== src.f ====
conv_pkg.sv
conv_line_buffer.sv
conv_window_ctrl.sv
conv_weight_bank.sv
conv_mac.sv
conv_result_fifo.sv
conv_wb_regs.sv
conv_layer_top.sv
tb_conv_layer.sv

// ==== Bender.yml ====
package:
  name: conv_layer

sources:
  - conv_pkg.sv
  - conv_line_buffer.sv
  - conv_window_ctrl.sv
  - conv_weight_bank.sv
  - conv_mac.sv
  - conv_result_fifo.sv
  - conv_wb_regs.sv
  - conv_layer_top.sv
  - target: test
    files:
      - tb_conv_layer.sv
